/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [15:0] instr_t;   // opcode in [15:8], argument in [7:0]
    typedef logic [63:0] word_t;

    typedef enum logic [7:0] {
        op_push   = 8'd0,   // 32-bit immediate in two words, low word first
        op_dup    = 8'd2,
        op_set    = 8'd3,
        op_jmp    = 8'd5,
        op_get    = 8'd6,
        op_hlt    = 8'd12,
        op_neg    = 8'd14,
        op_drop   = 8'd17,
        op_drop2  = 8'd18,
        op_swap   = 8'd19,
        op_over   = 8'd21,
        op_nop    = 8'd25,
        op_ifcmp  = 8'd27,
        op_if     = 8'd28,
        op_alu    = 8'd29,   // sub-op in argument bits 3:0
        op_bipush = 8'd32,
        op_sipush = 8'd33
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_shl,
        alu_lshr64, alu_lshr32, alu_ashr, alu_bit, alu_mul, alu_cmp
    } alu_op_e;

    function automatic opcode_e instr_opcode(instr_t instr);
        return opcode_e'(instr[15:8]);
    endfunction

    function automatic logic [7:0] instr_arg(instr_t instr);
        return instr[7:0];
    endfunction

endpackage

/* design/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    // data memory request, held stable while valid is high
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] write_data;
        logic        valid;
        logic        write;
    } mem_req_t;

    // one stack operation per clock, pointer moves first and the write
    // lands at the new pointer
    typedef struct packed {
        logic signed [2:0] delta;
        logic              write;
        logic [63:0]       data;
    } stack_cmd_t;

    localparam stack_cmd_t stack_idle = '0;

    function automatic stack_cmd_t stack_op(
        logic signed [2:0] delta,
        logic              write,
        logic [63:0]       data
    );
        stack_cmd_t cmd;
        cmd = '{delta: delta, write: write, data: data};
        return cmd;
    endfunction

endpackage

/* design/data_stack.sv */
`timescale 1ns/1ps

module data_stack
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int STACK_BITS = 6
) (
    input  logic       clk,
    input  logic       nreset,
    input  stack_cmd_t stack_cmd,
    output word_t      top,
    output word_t      next
);

    localparam int DEPTH = 2 ** STACK_BITS;

    word_t                 mem [DEPTH];
    logic [STACK_BITS-1:0] ptr;
    logic [STACK_BITS-1:0] ptr_next;
    logic [STACK_BITS-1:0] ptr_below;

    // the stack grows toward lower addresses, so a push has a negative delta
    assign ptr_next  = ptr + STACK_BITS'(stack_cmd.delta);
    assign ptr_below = ptr + 1'b1;     // wraps at the end of the memory

    always_ff @(posedge clk) begin
        if (!nreset) begin
            ptr <= '0;
        end else begin
            ptr <= ptr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (nreset && stack_cmd.write) begin
            mem[ptr_next] <= stack_cmd.data;
        end
    end

    // both reads are combinational so the sequencer sees them in decode
    assign top  = mem[ptr];
    assign next = mem[ptr_below];

endmodule

/* design/stack_alu.sv */
`timescale 1ns/1ps

module stack_alu
    import cpu_isa_pkg::*;
(
    input  word_t  top,
    input  word_t  next,
    input  instr_t instruction,
    output word_t  alu_result,
    output logic   alu_illegal,
    output logic   if_pass,
    output logic   ifcmp_pass
);

    logic       eq, gt, lt;
    logic       zero, negative;
    logic       invert;
    logic [1:0] flags;
    logic [1:0] cond_sel;
    logic [1:0] cmp_sel;

    assign eq       = next == top;
    assign gt       = $signed(next) > $signed(top);
    assign lt       = !eq && !gt;
    assign zero     = top == '0;
    assign negative = top[63];

    assign invert   = instruction[2];
    assign flags    = instruction[1:0];
    assign cond_sel = flags & {negative, zero};
    assign cmp_sel  = flags & {gt, eq};

    assign if_pass    = (|cond_sel) ^ invert;
    assign ifcmp_pass = (|cmp_sel) ^ invert;

    // sub-ops 12 to 15 are not defined
    assign alu_illegal = instruction[3:0] > 4'd11;

    always_comb begin
        case (alu_op_e'(instruction[3:0]))
            alu_add:    alu_result = next + top;
            alu_sub:    alu_result = next - top;
            alu_and:    alu_result = next & top;
            alu_or:     alu_result = next | top;
            alu_xor:    alu_result = next ^ top;
            alu_shl:    alu_result = next << top[5:0];
            alu_lshr64: alu_result = next >> top[5:0];
            alu_lshr32: alu_result = {32'h0, next[31:0] >> top[4:0]};
            alu_ashr:   alu_result = $signed(next) >>> top[5:0];
            alu_bit:    alu_result = {63'h0, next[top[5:0]]};
            alu_mul:    alu_result = $signed(next) * $signed(top);
            alu_cmp:    alu_result = {{63{lt}}, !eq};   // -1, 0 or 1
            default:    alu_result = '0;
        endcase
    end

endmodule

/* design/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int CODE_BITS = 10
) (
    input  logic                 clk,
    input  logic                 nreset,
    output logic [CODE_BITS-1:0] instr_address,
    input  instr_t               instr_data,
    output mem_req_t             mem_req,
    input  logic [31:0]          mem_data_in,
    input  logic                 mem_ready,
    input  word_t                top,
    input  word_t                next,
    input  word_t                alu_result,
    input  logic                 alu_illegal,
    input  logic                 if_pass,
    input  logic                 ifcmp_pass,
    output stack_cmd_t           stack_cmd,
    output instr_t               instruction,
    output logic                 error,
    output logic                 hlt
);

    typedef enum logic [2:0] {
        fetch,
        decode,
        imm_high,
        swap_second,
        mem_wait
    } state_e;

    state_e               state;
    logic [CODE_BITS-1:0] pc;
    word_t                swap_temp;
    logic [15:0]          push_low;
    opcode_e              opcode;
    logic                 run;
    logic                 null_addr;
    logic [31:0]          branch_offset;
    logic [CODE_BITS-1:0] branch_target;
    logic [CODE_BITS-1:0] pc_step;
    word_t                imm16;
    word_t                imm32;
    word_t                imm8;
    word_t                mem_word;

    assign opcode        = instr_opcode(instruction);
    assign hlt           = opcode == op_hlt;
    assign run           = !error && !hlt;   // frozen until reset
    assign instr_address = pc;

    assign null_addr     = top[31:0] == 32'h0;
    assign branch_offset = {{16{instr_data[15]}}, instr_data};
    assign branch_target = pc + branch_offset[CODE_BITS-1:0];
    assign pc_step       = pc + 1'b1;

    assign imm8     = {{56{instruction[7]}}, instr_arg(instruction)};
    assign imm16    = {{48{instr_data[15]}}, instr_data};
    assign imm32    = {{32{instr_data[15]}}, instr_data, push_low};
    assign mem_word = {{32{mem_data_in[31]}}, mem_data_in};

    // stack operations are issued in the cycle that executes them
    always_comb begin
        stack_cmd = stack_idle;
        if (run) begin
            case (state)
                decode: begin
                    case (opcode)
                        op_sipush: stack_cmd = stack_op(-3'sd1, 1'b1, imm16);
                        op_bipush: stack_cmd = stack_op(-3'sd1, 1'b1, imm8);
                        op_dup:    stack_cmd = stack_op(-3'sd1, 1'b1, top);
                        op_over:   stack_cmd = stack_op(-3'sd1, 1'b1, next);
                        op_drop:   stack_cmd = stack_op(3'sd1, 1'b0, '0);
                        op_drop2:  stack_cmd = stack_op(3'sd2, 1'b0, '0);
                        op_swap:   stack_cmd = stack_op(3'sd1, 1'b1, top);
                        op_neg:    stack_cmd = stack_op(3'sd0, 1'b1, -top);
                        op_if:     stack_cmd = stack_op(3'sd1, 1'b0, '0);
                        op_ifcmp:  stack_cmd = stack_op(3'sd2, 1'b0, '0);
                        op_alu: begin
                            if (!alu_illegal) begin
                                stack_cmd = stack_op(3'sd1, 1'b1, alu_result);
                            end
                        end
                        op_set: begin
                            // address and data are already captured in the request
                            if (!null_addr) begin
                                stack_cmd = stack_op(3'sd2, 1'b0, '0);
                            end
                        end
                        default: stack_cmd = stack_idle;
                    endcase
                end
                imm_high:    stack_cmd = stack_op(-3'sd1, 1'b1, imm32);
                swap_second: stack_cmd = stack_op(-3'sd1, 1'b1, swap_temp);
                mem_wait: begin
                    if (mem_ready && !mem_req.write) begin
                        stack_cmd = stack_op(3'sd0, 1'b1, mem_word);  // get result
                    end
                end
                default: stack_cmd = stack_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state         <= fetch;
            pc            <= '0;
            instruction   <= {op_nop, 8'h00};
            error         <= 1'b0;
            mem_req.valid <= 1'b0;
            mem_req.write <= 1'b0;
        end else if (run) begin
            case (state)
                fetch: begin
                    instruction <= instr_data;
                    pc          <= pc_step;
                    state       <= decode;
                end
                decode: begin
                    state <= fetch;
                    case (opcode)
                        op_push: begin
                            push_low <= instr_data;
                            pc       <= pc_step;
                            state    <= imm_high;
                        end
                        op_sipush: pc <= pc_step;
                        op_jmp:    pc <= branch_target;
                        op_if:     pc <= if_pass ? branch_target : pc_step;
                        op_ifcmp:  pc <= ifcmp_pass ? branch_target : pc_step;
                        op_swap: begin
                            swap_temp <= next;
                            state     <= swap_second;
                        end
                        op_get, op_set: begin
                            if (null_addr) begin
                                error <= 1'b1;
                            end else begin
                                mem_req <= '{address: top[31:0], write_data: next[31:0],
                                             valid: 1'b1, write: opcode == op_set};
                                state   <= mem_wait;
                            end
                        end
                        op_alu: error <= alu_illegal;
                        op_dup, op_over, op_drop, op_drop2, op_neg, op_bipush, op_nop,
                        op_hlt: state <= fetch;
                        default: error <= 1'b1;   // unknown opcode
                    endcase
                end
                imm_high: begin
                    pc    <= pc_step;
                    state <= fetch;
                end
                swap_second: state <= fetch;
                mem_wait: begin
                    if (mem_ready) begin
                        mem_req.valid <= 1'b0;
                        mem_req.write <= 1'b0;
                        state         <= fetch;
                    end
                end
                default: state <= fetch;
            endcase
        end
    end

endmodule

/* design/stack_cpu.sv */
`timescale 1ns/1ps

module stack_cpu
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
#(
    parameter int STACK_BITS = 6,
    parameter int CODE_BITS  = 10
) (
    input  logic                 clk,
    input  logic                 nreset,
    output logic [CODE_BITS-1:0] instr_address,
    input  instr_t               instr_data,
    output mem_req_t             mem_req,
    input  logic [31:0]          mem_data_in,
    input  logic                 mem_ready,
    output logic                 error,
    output logic                 hlt
);

    stack_cmd_t stack_cmd;
    instr_t     instruction;
    word_t      top;
    word_t      next;
    word_t      alu_result;
    logic       alu_illegal;
    logic       if_pass;
    logic       ifcmp_pass;

    cpu_control #(
        .CODE_BITS (CODE_BITS)
    ) u_control (
        .clk           (clk),
        .nreset        (nreset),
        .instr_address (instr_address),
        .instr_data    (instr_data),
        .mem_req       (mem_req),
        .mem_data_in   (mem_data_in),
        .mem_ready     (mem_ready),
        .top           (top),
        .next          (next),
        .alu_result    (alu_result),
        .alu_illegal   (alu_illegal),
        .if_pass       (if_pass),
        .ifcmp_pass    (ifcmp_pass),
        .stack_cmd     (stack_cmd),
        .instruction   (instruction),
        .error         (error),
        .hlt           (hlt)
    );

    data_stack #(
        .STACK_BITS (STACK_BITS)
    ) u_stack (
        .clk       (clk),
        .nreset    (nreset),
        .stack_cmd (stack_cmd),
        .top       (top),
        .next      (next)
    );

    stack_alu u_alu (
        .top         (top),
        .next        (next),
        .instruction (instruction),
        .alu_result  (alu_result),
        .alu_illegal (alu_illegal),
        .if_pass     (if_pass),
        .ifcmp_pass  (ifcmp_pass)
    );

endmodule

/* verif/stack_cpu_tb.sv */
`timescale 1ns/1ps

module stack_cpu_tb
    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;
();

    localparam int CODE_BITS = 10;

    logic                 clk = 1'b0;
    logic                 nreset = 1'b0;
    logic [CODE_BITS-1:0] instr_address;
    instr_t               instr_data;
    mem_req_t             mem_req;
    logic [31:0]          mem_data_in = '0;
    logic                 mem_ready = 1'b0;
    logic                 error;
    logic                 hlt;

    instr_t      imem [2**CODE_BITS];
    logic [31:0] dmem [256];   // indexed by the low address byte
    logic [15:0] lfsr = 16'd43;
    string       test_name;
    bit          pending;
    int          wait_left;
    int          prog_len;
    int          req_count;
    int          write_count;
    int          test_fails;
    int          errors;
    int          tests_run;
    int          tests_failed;

    always #5 clk = ~clk;

    assign instr_data = imem[instr_address];   // combinational instruction port

    stack_cpu #(
        .STACK_BITS (6),
        .CODE_BITS  (CODE_BITS)
    ) UUT (
        .clk           (clk),
        .nreset        (nreset),
        .instr_address (instr_address),
        .instr_data    (instr_data),
        .mem_req       (mem_req),
        .mem_data_in   (mem_data_in),
        .mem_ready     (mem_ready),
        .error         (error),
        .hlt           (hlt)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [63:0] sext32(logic [31:0] value);
        return {{32{value[31]}}, value};
    endfunction

    // a is next and b is top, as the sub-ops see them
    function automatic logic [63:0] alu_model(int op, logic [63:0] a, logic [63:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return a << b[5:0];
            6:       return a >> b[5:0];
            7:       return (a & 64'hffff_ffff) >> (b & 64'd31);
            8:       return $signed(a) >>> b[5:0];
            9:       return 64'(a[b[5:0]]);
            10:      return a * b;
            default: return ($signed(a) < $signed(b)) ? '1 : 64'(a != b);
        endcase
    endfunction

    function automatic instr_t op_word(opcode_e op, logic [7:0] arg);
        return {op, arg};
    endfunction

    task automatic report_problem(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
        test_fails++;
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
            test_fails++;
        end
    endtask

    // data memory with a random ready delay of 0 to 3 cycles
    always @(negedge clk) begin
        if (!nreset) begin
            mem_ready = 1'b0;
            pending   = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;   // accepted at the last rising edge
            pending   = 1'b0;
            assert (!mem_req.valid) else report_problem("valid still high after the handshake");
        end else if (mem_req.valid) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = random_bits(2);
                req_count++;
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                if (mem_req.write) begin
                    dmem[mem_req.address[7:0]] = mem_req.write_data;
                    write_count++;
                end else begin
                    mem_data_in = dmem[mem_req.address[7:0]];
                end
            end else begin
                wait_left--;
            end
        end else begin
            assert (!pending) else report_problem("mem_req.valid dropped before mem_ready");
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_fails  = 0;
        prog_len    = 0;
        req_count   = 0;
        write_count = 0;
        for (int i = 0; i < 2**CODE_BITS; i++) begin
            imem[i] = op_word(op_hlt, 8'(i ^ (i >> 8)));   // spare words halt
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {16'hd00d, 8'(i), 8'(i ^ 8'h5a)};
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_fails == 0) begin
            $display("%-14s ok", test_name);
        end else begin
            $display("%-14s %0d error(s)", test_name, test_fails);
            tests_failed++;
        end
    endtask

    task automatic emit(input instr_t word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_push(input logic [31:0] value);
        emit(op_word(op_push, 8'h00));
        emit(value[15:0]);
        emit(value[31:16]);
    endtask

    // set stores next at the address in top
    task automatic emit_store(input logic [7:0] address);
        emit(op_word(op_bipush, address));
        emit(op_word(op_set, 8'h00));
    endtask

    task automatic run_program(input bit expect_error);
        int cycles;
        cycles = 0;
        nreset = 1'b0;
        repeat (10) @(negedge clk);
        nreset = 1'b1;
        while (hlt !== 1'b1 && error !== 1'b1 && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (hlt !== 1'b1 && error !== 1'b1) begin
            report_problem("timed out waiting for hlt or error");
        end else begin
            check_value("error", 64'(expect_error), 64'(error));
            check_value("hlt", 64'(!expect_error), 64'(hlt));
        end
    endtask

    task automatic immediate_pushes();
        start_test("immediates");
        emit_push(32'hfffe_1dc0);
        emit_store(8'h20);
        emit_push(32'h1234_5678);
        emit_store(8'h21);
        emit(op_word(op_sipush, 8'h00));
        emit(16'h8001);
        emit_store(8'h22);
        emit(op_word(op_sipush, 8'h00));
        emit(16'h1234);
        emit_store(8'h23);
        emit(op_word(op_bipush, 8'hfb));
        emit_store(8'h24);
        emit(op_word(op_bipush, 8'h64));
        emit_store(8'h25);
        run_program(1'b0);
        check_value("push negative", 64'hfffe_1dc0, dmem[8'h20]);
        check_value("push positive", 64'h1234_5678, dmem[8'h21]);
        check_value("sipush negative", 64'hffff_8001, dmem[8'h22]);
        check_value("sipush positive", 64'h0000_1234, dmem[8'h23]);
        check_value("bipush negative", 64'hffff_fffb, dmem[8'h24]);
        check_value("bipush positive", 64'h0000_0064, dmem[8'h25]);
        check_value("writes", 64'd6, write_count);
        finish_test();
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected [12];
        start_test("alu");
        for (int op = 0; op < 12; op++) begin
            a = random_bits(32);
            b = random_bits(32);
            expected[op] = alu_model(op, sext32(a), sext32(b));
            emit_push(a);
            emit_push(b);
            emit(op_word(op_alu, 8'(op)));
            emit_store(8'(8'h10 + op));
        end
        run_program(1'b0);
        for (int op = 0; op < 12; op++) begin
            check_value($sformatf("sub-op %0d", op), expected[op][31:0], dmem[8'h10 + op]);
        end
        check_value("writes", 64'd12, write_count);
        finish_test();
    endtask

    task automatic stack_shuffles();
        start_test("shuffles");
        for (int v = 1; v <= 4; v++) begin
            emit(op_word(op_bipush, 8'(v)));
        end
        emit(op_word(op_over, 8'h00));   // 3 4 3 2 1, top first
        emit(op_word(op_swap, 8'h00));   // 4 3 3 2 1
        emit_store(8'h30);
        emit(op_word(op_neg, 8'h00));    // -3 3 2 1
        emit_store(8'h31);
        emit(op_word(op_drop, 8'h00));   // 2 1
        emit(op_word(op_bipush, 8'h07));
        emit(op_word(op_bipush, 8'h08));
        emit(op_word(op_drop2, 8'h00));  // 2 1
        emit(op_word(op_dup, 8'h00));
        emit(op_word(op_neg, 8'h00));    // -2 2 1
        emit_store(8'h32);
        emit_store(8'h33);
        emit_store(8'h34);
        run_program(1'b0);
        check_value("swap", 64'h4, dmem[8'h30]);
        check_value("neg", 64'hffff_fffd, dmem[8'h31]);
        check_value("dup and neg", 64'hffff_fffe, dmem[8'h32]);
        check_value("drop", 64'h2, dmem[8'h33]);
        check_value("bottom", 64'h1, dmem[8'h34]);
        check_value("writes", 64'd5, write_count);
        finish_test();
    endtask

    // branch offsets count from the address of the offset word
    task automatic counted_loop();
        int passes;
        int loop_addr;
        int exit_fix;
        start_test("branches");
        passes = random_bits(3) + 2;
        emit(op_word(op_bipush, 8'h00));
        loop_addr = prog_len;
        emit(op_word(op_dup, 8'h00));
        emit(op_word(op_bipush, 8'(passes)));
        emit(op_word(op_ifcmp, 8'h01));   // leave when the count equals passes
        exit_fix = prog_len;
        emit(16'h0000);
        emit(op_word(op_bipush, 8'h01));
        emit(op_word(op_alu, 8'd0));
        emit(op_word(op_dup, 8'h00));
        emit_store(8'h40);
        emit(op_word(op_dup, 8'h00));
        emit(op_word(op_if, 8'h05));      // taken while the count is not zero
        emit(16'd2);
        emit(op_word(op_hlt, 8'h00));
        emit(op_word(op_jmp, 8'h00));
        emit(16'(loop_addr - prog_len));
        imem[exit_fix] = 16'(prog_len - exit_fix);
        emit(op_word(op_hlt, 8'h00));
        run_program(1'b0);
        check_value("stored count", passes, dmem[8'h40]);
        check_value("writes", passes, write_count);
        finish_test();
    endtask

    task automatic memory_reads();
        logic [31:0] value;
        start_test("memory reads");
        value = random_bits(32);
        dmem[8'h50] = 32'h8000_1234;
        dmem[8'h51] = value;
        for (int k = 0; k < 2; k++) begin
            emit(op_word(op_bipush, 8'(8'h50 + k)));
            emit(op_word(op_get, 8'h00));
            emit(op_word(op_dup, 8'h00));
            emit_store(8'(8'h60 + 2 * k));
            emit(op_word(op_bipush, 8'd32));
            emit(op_word(op_alu, 8'd6));  // upper half shows the sign extension
            emit_store(8'(8'h61 + 2 * k));
        end
        run_program(1'b0);
        check_value("negative word", 64'h8000_1234, dmem[8'h60]);
        check_value("negative upper", 64'hffff_ffff, dmem[8'h61]);
        check_value("random word", value, dmem[8'h62]);
        check_value("random upper", {32{value[31]}}, dmem[8'h63]);
        check_value("requests", 64'd6, req_count);
        finish_test();
    endtask

    task automatic error_stop(input string name, input instr_t bad_word);
        start_test(name);
        emit(op_word(op_bipush, 8'h01));
        emit(op_word(op_bipush, 8'h00));  // zero address for get
        emit(bad_word);
        emit(op_word(op_bipush, 8'h09));
        emit_store(8'h70);
        run_program(1'b1);
        repeat (8) @(negedge clk);
        check_value("error held", 64'h1, error);
        check_value("requests", 64'd0, req_count);
        check_value("writes", 64'd0, write_count);
        finish_test();
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        start_test("setup");
        immediate_pushes();
        alu_ops();
        stack_shuffles();
        counted_loop();
        memory_reads();
        error_stop("null get", op_word(op_get, 8'h00));
        error_stop("bad opcode", 16'hff00);
        error_stop("bad alu op", op_word(op_alu, 8'd13));
        $display("tests run %0d, tests with errors %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
design/cpu_isa_pkg.sv
design/cpu_bus_pkg.sv
design/data_stack.sv
design/stack_alu.sv
design/cpu_control.sv
design/stack_cpu.sv
verif/stack_cpu_tb.sv
